// File: verilog/cpu_arch_pkg.sv
package cpu_arch_pkg;

    localparam int DATA_W = 32;
    localparam int WORD_W = 16;
    localparam int ADDR_W = 12;
    localparam int SP_W   = 10;
    localparam int REG_AW = 3;

    localparam logic [ADDR_W-SP_W-1:0] STACK_BASE = '1; // Top 1024 words
    localparam logic [SP_W-1:0]        SP_RESET   = '1;
    localparam int                     LOAD_WORDS = 128;
    localparam logic [ADDR_W-1:0]      START_ADDR = '0;
    localparam logic [REG_AW-1:0]      COND_REG   = 3'd5; // Tested by conditional jumps

    typedef enum logic [2:0] {
        ST_LOAD,
        ST_FETCH,
        ST_EXEC,
        ST_READ_HI,
        ST_READ_LO,
        ST_RET_JUMP,
        ST_WRITE,
        ST_HALT
    } state_e;

endpackage

// File: verilog/cpu_isa_pkg.sv
package cpu_isa_pkg;

    localparam int CLASS_BIT = 15; // 1 selects branch format
    localparam int MAJ_HI    = 14;
    localparam int MAJ_LO    = 11;
    localparam int COND_HI   = 14;
    localparam int COND_LO   = 12;
    localparam int TGT_HI    = 11;
    localparam int TGT_LO    = 0;
    localparam int RD_HI     = 10;
    localparam int RD_LO     = 8;
    localparam int RS0_HI    = 7;
    localparam int RS0_LO    = 5;
    localparam int RS1_HI    = 4;
    localparam int RS1_LO    = 2;
    localparam int MIN_HI    = 4;
    localparam int MIN_LO    = 0;
    localparam int FN_HI     = 1;
    localparam int FN_LO     = 0;
    localparam int IMM_HI    = 7;
    localparam int IMM_LO    = 0;

    typedef enum logic [3:0] {
        MJ_MISC, MJ_ALU_RR, MJ_LOGIC_RR, MJ_STORE,
        MJ_MOVLL, MJ_MOVLH, MJ_MOVHL, MJ_MOVHH,
        MJ_ADDB, MJ_SUBB
    } major_e;

    typedef enum logic [4:0] {
        MN_END    = 5'b00000, MN_RET    = 5'b00001, MN_NOP    = 5'b00011,
        MN_OUT    = 5'b01100, MN_PUSHL  = 5'b01101, MN_PUSHH  = 5'b01110,
        MN_MOV    = 5'b10000, MN_NOT    = 5'b10001, MN_NEG    = 5'b10010,
        MN_LDRAML = 5'b11000, MN_LDRAMH = 5'b11001,
        MN_POPL   = 5'b11010, MN_POPH   = 5'b11011, MN_MOVD   = 5'b11111
    } minor_e;

    // Signed tests on the condition register
    typedef enum logic [2:0] {
        BR_CALL, BR_JMP, BR_JEZ, BR_JNZ, BR_JAZ, BR_JBZ, BR_JAEZ, BR_JBEZ
    } branch_e;

    typedef enum logic [3:0] {
        ALU_PASS, ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_NOT, ALU_NEG, ALU_BYTE_INS
    } alu_op_e;

    typedef enum logic [4:0] {
        IC_WB_ALU, IC_LOAD_L, IC_LOAD_H, IC_POP_L, IC_POP_H, IC_IMM32,
        IC_STORE_L, IC_STORE_H, IC_PUSH_L, IC_PUSH_H, IC_OUT, IC_CALL,
        IC_JUMP, IC_RET, IC_NOP, IC_HALT, IC_ILLEGAL
    } ins_class_e;

endpackage

// File: verilog/regfile.sv
`timescale 1ns/1ns

module regfile (
    input  logic                             CLK,
    input  logic [cpu_arch_pkg::REG_AW-1:0] ra0,
    input  logic [cpu_arch_pkg::REG_AW-1:0] ra1,
    input  logic [cpu_arch_pkg::REG_AW-1:0] wa,
    input  logic [cpu_arch_pkg::DATA_W-1:0] wdata,
    input  logic                             we_h,
    input  logic                             we_l,
    output logic [cpu_arch_pkg::DATA_W-1:0] rd0,
    output logic [cpu_arch_pkg::DATA_W-1:0] rd1
);

    localparam int HW = cpu_arch_pkg::WORD_W;

    logic [cpu_arch_pkg::DATA_W-1:0] regs [2**cpu_arch_pkg::REG_AW];

    always_ff @(posedge CLK) begin
        if (we_h)
            regs[wa][cpu_arch_pkg::DATA_W-1:HW] <= wdata[cpu_arch_pkg::DATA_W-1:HW];
        if (we_l)
            regs[wa][HW-1:0] <= wdata[HW-1:0];
    end

    assign rd0 = regs[ra0];
    assign rd1 = regs[ra1];

endmodule

// File: verilog/alu.sv
`timescale 1ns/1ns

module alu (
    input  cpu_isa_pkg::alu_op_e             op,
    input  logic [cpu_arch_pkg::DATA_W-1:0] arg0,
    input  logic [cpu_arch_pkg::DATA_W-1:0] arg1,
    input  logic [1:0]                       byte_sel,
    input  logic [7:0]                       imm,
    output logic [cpu_arch_pkg::DATA_W-1:0] result
);

    always_comb begin
        result = arg0;
        case (op)
            cpu_isa_pkg::ALU_ADD:      result = arg0 + arg1;
            cpu_isa_pkg::ALU_SUB:      result = arg0 - arg1;
            cpu_isa_pkg::ALU_AND:      result = arg0 & arg1;
            cpu_isa_pkg::ALU_OR:       result = arg0 | arg1;
            cpu_isa_pkg::ALU_XOR:      result = arg0 ^ arg1;
            cpu_isa_pkg::ALU_NOT:      result = ~arg0;
            cpu_isa_pkg::ALU_NEG:      result = -arg0;
            cpu_isa_pkg::ALU_BYTE_INS: result[byte_sel*8 +: 8] = imm; // MOVLL..MOVHH
            default:                   result = arg0; // PASS for MOV and OUT
        endcase
    end

endmodule

// File: verilog/instr_decode.sv
`timescale 1ns/1ns

module instr_decode (
    input  logic [cpu_arch_pkg::WORD_W-1:0] instr,
    output cpu_isa_pkg::ins_class_e          ins_class,
    output cpu_isa_pkg::alu_op_e             alu_op,
    output logic                             use_imm,
    output logic [1:0]                       byte_sel,
    output cpu_isa_pkg::branch_e             branch,
    output logic [cpu_arch_pkg::REG_AW-1:0] ra0,
    output logic [cpu_arch_pkg::REG_AW-1:0] ra1,
    output logic [cpu_arch_pkg::REG_AW-1:0] wa,
    output logic [7:0]                       imm,
    output logic [cpu_arch_pkg::ADDR_W-1:0] target
);

    cpu_isa_pkg::major_e              major;
    cpu_isa_pkg::minor_e              minor;
    logic [1:0]                       fn;
    logic [cpu_arch_pkg::REG_AW-1:0] rd;
    logic [cpu_arch_pkg::REG_AW-1:0] rs0;

    assign major    = cpu_isa_pkg::major_e'(instr[cpu_isa_pkg::MAJ_HI:cpu_isa_pkg::MAJ_LO]);
    assign minor    = cpu_isa_pkg::minor_e'(instr[cpu_isa_pkg::MIN_HI:cpu_isa_pkg::MIN_LO]);
    assign branch   = cpu_isa_pkg::branch_e'(instr[cpu_isa_pkg::COND_HI:cpu_isa_pkg::COND_LO]);
    assign fn       = instr[cpu_isa_pkg::FN_HI:cpu_isa_pkg::FN_LO];
    assign rd       = instr[cpu_isa_pkg::RD_HI:cpu_isa_pkg::RD_LO];
    assign rs0      = instr[cpu_isa_pkg::RS0_HI:cpu_isa_pkg::RS0_LO];
    assign ra1      = instr[cpu_isa_pkg::RS1_HI:cpu_isa_pkg::RS1_LO];
    assign imm      = instr[cpu_isa_pkg::IMM_HI:cpu_isa_pkg::IMM_LO];
    assign target   = instr[cpu_isa_pkg::TGT_HI:cpu_isa_pkg::TGT_LO];
    assign byte_sel = instr[cpu_isa_pkg::MAJ_LO+1:cpu_isa_pkg::MAJ_LO]; // Low bits of MOVxx
    assign wa       = rd;

    always_comb begin
        ins_class = cpu_isa_pkg::IC_ILLEGAL;
        alu_op    = cpu_isa_pkg::ALU_PASS;
        use_imm   = 1'b0;
        ra0       = rs0;
        if (instr[cpu_isa_pkg::CLASS_BIT]) begin
            ra0       = cpu_arch_pkg::COND_REG;
            ins_class = (branch == cpu_isa_pkg::BR_CALL) ? cpu_isa_pkg::IC_CALL
                                                         : cpu_isa_pkg::IC_JUMP;
        end else begin
            case (major)
                cpu_isa_pkg::MJ_MISC: begin
                    case (minor)
                        cpu_isa_pkg::MN_END:    ins_class = cpu_isa_pkg::IC_HALT;
                        cpu_isa_pkg::MN_RET:    ins_class = cpu_isa_pkg::IC_RET;
                        cpu_isa_pkg::MN_NOP:    ins_class = cpu_isa_pkg::IC_NOP;
                        cpu_isa_pkg::MN_OUT:    ins_class = cpu_isa_pkg::IC_OUT;
                        cpu_isa_pkg::MN_PUSHL:  ins_class = cpu_isa_pkg::IC_PUSH_L;
                        cpu_isa_pkg::MN_PUSHH:  ins_class = cpu_isa_pkg::IC_PUSH_H;
                        cpu_isa_pkg::MN_MOV:    ins_class = cpu_isa_pkg::IC_WB_ALU;
                        cpu_isa_pkg::MN_NOT: begin
                            ins_class = cpu_isa_pkg::IC_WB_ALU;
                            alu_op    = cpu_isa_pkg::ALU_NOT;
                        end
                        cpu_isa_pkg::MN_NEG: begin
                            ins_class = cpu_isa_pkg::IC_WB_ALU;
                            alu_op    = cpu_isa_pkg::ALU_NEG;
                        end
                        cpu_isa_pkg::MN_LDRAML: ins_class = cpu_isa_pkg::IC_LOAD_L;
                        cpu_isa_pkg::MN_LDRAMH: ins_class = cpu_isa_pkg::IC_LOAD_H;
                        cpu_isa_pkg::MN_POPL:   ins_class = cpu_isa_pkg::IC_POP_L;
                        cpu_isa_pkg::MN_POPH:   ins_class = cpu_isa_pkg::IC_POP_H;
                        cpu_isa_pkg::MN_MOVD:   ins_class = cpu_isa_pkg::IC_IMM32;
                        default:                ins_class = cpu_isa_pkg::IC_ILLEGAL;
                    endcase
                end
                cpu_isa_pkg::MJ_ALU_RR: begin
                    if (fn < 2'd2)
                        ins_class = cpu_isa_pkg::IC_WB_ALU;
                    alu_op = fn[0] ? cpu_isa_pkg::ALU_SUB : cpu_isa_pkg::ALU_ADD;
                end
                cpu_isa_pkg::MJ_LOGIC_RR: begin
                    if (fn != 2'd3)
                        ins_class = cpu_isa_pkg::IC_WB_ALU; // Function 3 unused
                    alu_op = fn[1] ? cpu_isa_pkg::ALU_XOR
                                   : (fn[0] ? cpu_isa_pkg::ALU_OR : cpu_isa_pkg::ALU_AND);
                end
                cpu_isa_pkg::MJ_STORE: begin
                    if (fn == 2'd0)
                        ins_class = cpu_isa_pkg::IC_STORE_L;
                    else if (fn == 2'd1)
                        ins_class = cpu_isa_pkg::IC_STORE_H;
                end
                cpu_isa_pkg::MJ_MOVLL, cpu_isa_pkg::MJ_MOVLH,
                cpu_isa_pkg::MJ_MOVHL, cpu_isa_pkg::MJ_MOVHH: begin
                    ins_class = cpu_isa_pkg::IC_WB_ALU;
                    alu_op    = cpu_isa_pkg::ALU_BYTE_INS;
                    ra0       = rd;
                end
                cpu_isa_pkg::MJ_ADDB, cpu_isa_pkg::MJ_SUBB: begin
                    ins_class = cpu_isa_pkg::IC_WB_ALU;
                    alu_op    = (major == cpu_isa_pkg::MJ_SUBB) ? cpu_isa_pkg::ALU_SUB
                                                                : cpu_isa_pkg::ALU_ADD;
                    use_imm   = 1'b1;
                    ra0       = rd;
                end
                default: ins_class = cpu_isa_pkg::IC_ILLEGAL;
            endcase
        end
    end

endmodule

// File: verilog/core_control.sv
`timescale 1ns/1ns

module core_control (
    input  logic                             CLK,
    input  logic                             rst,
    input  logic                             flash_valid,
    input  logic [cpu_arch_pkg::WORD_W-1:0] flash_data,
    input  logic [cpu_arch_pkg::WORD_W-1:0] ram_q,
    output logic [cpu_arch_pkg::ADDR_W-1:0] ram_addr,
    output logic [cpu_arch_pkg::WORD_W-1:0] ram_wdata,
    output logic                             ram_wren,
    input  cpu_isa_pkg::ins_class_e          ins_class,
    input  cpu_isa_pkg::branch_e             branch,
    input  logic [cpu_arch_pkg::ADDR_W-1:0] target,
    input  logic [cpu_arch_pkg::DATA_W-1:0] rd0,
    input  logic [cpu_arch_pkg::DATA_W-1:0] rd1,
    input  logic [cpu_arch_pkg::DATA_W-1:0] alu_result,
    input  logic [cpu_arch_pkg::REG_AW-1:0] wa_dec,
    output logic [cpu_arch_pkg::REG_AW-1:0] reg_wa,
    output logic [cpu_arch_pkg::DATA_W-1:0] reg_wdata,
    output logic                             reg_we_h,
    output logic                             reg_we_l,
    output logic [cpu_arch_pkg::DATA_W-1:0] out_data,
    output logic                             halted
);

    localparam int AW = cpu_arch_pkg::ADDR_W;
    localparam int WW = cpu_arch_pkg::WORD_W;
    localparam int DW = cpu_arch_pkg::DATA_W;

    cpu_arch_pkg::state_e            state;
    logic [AW-1:0]                   ip;
    logic [AW-1:0]                   ip_inc;
    logic [cpu_arch_pkg::SP_W-1:0]   sp;
    logic [cpu_arch_pkg::SP_W-1:0]   sp_inc;
    logic [cpu_arch_pkg::SP_W-1:0]   sp_dec;
    logic [cpu_arch_pkg::REG_AW-1:0] ld_wa;    // Load destination for READ states
    logic                            ld_imm32;
    logic [AW-1:0]                   wr_addr;
    logic [WW-1:0]                   wr_data;
    logic                            exec_wb;
    logic                            zero;
    logic                            neg;
    logic                            taken;

    assign ip_inc  = ip + 1'b1;
    assign sp_inc  = sp + 1'b1;
    assign sp_dec  = sp - 1'b1;
    assign zero    = (rd0 == '0);
    assign neg     = rd0[DW-1];
    assign exec_wb = (state == cpu_arch_pkg::ST_EXEC) && (ins_class == cpu_isa_pkg::IC_WB_ALU);

    always_comb begin
        case (branch)
            cpu_isa_pkg::BR_JEZ:  taken = zero;
            cpu_isa_pkg::BR_JNZ:  taken = !zero;
            cpu_isa_pkg::BR_JAZ:  taken = !neg && !zero;
            cpu_isa_pkg::BR_JBZ:  taken = neg;
            cpu_isa_pkg::BR_JAEZ: taken = !neg;
            cpu_isa_pkg::BR_JBEZ: taken = neg || zero;
            default:              taken = 1'b1; // JMP
        endcase
    end

    always_comb begin
        ram_addr = ip;
        if (state == cpu_arch_pkg::ST_WRITE)
            ram_addr = wr_addr;
        else if (state == cpu_arch_pkg::ST_EXEC) begin
            case (ins_class)
                cpu_isa_pkg::IC_LOAD_L, cpu_isa_pkg::IC_LOAD_H:
                    ram_addr = rd0[AW-1:0];
                cpu_isa_pkg::IC_POP_L, cpu_isa_pkg::IC_POP_H, cpu_isa_pkg::IC_RET:
                    ram_addr = {cpu_arch_pkg::STACK_BASE, sp_inc};
                cpu_isa_pkg::IC_IMM32:
                    ram_addr = ip_inc; // High word follows the opcode
                default:
                    ram_addr = ip;
            endcase
        end
    end

    assign ram_wdata = (state == cpu_arch_pkg::ST_LOAD) ? flash_data : wr_data;
    assign ram_wren  = ((state == cpu_arch_pkg::ST_LOAD) && flash_valid) ||
                       (state == cpu_arch_pkg::ST_WRITE);

    assign reg_wa    = (state == cpu_arch_pkg::ST_EXEC) ? wa_dec : ld_wa;
    assign reg_wdata = (state == cpu_arch_pkg::ST_EXEC) ? alu_result : {ram_q, ram_q};
    assign reg_we_h  = exec_wb || (state == cpu_arch_pkg::ST_READ_HI);
    assign reg_we_l  = exec_wb || (state == cpu_arch_pkg::ST_READ_LO);
    assign halted    = (state == cpu_arch_pkg::ST_HALT);

    always_ff @(posedge CLK) begin
        if (rst) begin
            state    <= cpu_arch_pkg::ST_LOAD;
            ip       <= '0;
            sp       <= cpu_arch_pkg::SP_RESET;
            out_data <= '0;
        end else begin
            case (state)
                cpu_arch_pkg::ST_LOAD: begin
                    if (flash_valid) begin
                        if (ip == AW'(cpu_arch_pkg::LOAD_WORDS - 1)) begin
                            ip    <= cpu_arch_pkg::START_ADDR;
                            state <= cpu_arch_pkg::ST_FETCH;
                        end else
                            ip <= ip_inc;
                    end
                end
                cpu_arch_pkg::ST_FETCH: state <= cpu_arch_pkg::ST_EXEC;
                cpu_arch_pkg::ST_EXEC: begin
                    ip    <= ip_inc;
                    state <= cpu_arch_pkg::ST_FETCH;
                    case (ins_class)
                        cpu_isa_pkg::IC_LOAD_L: state <= cpu_arch_pkg::ST_READ_LO;
                        cpu_isa_pkg::IC_LOAD_H: state <= cpu_arch_pkg::ST_READ_HI;
                        cpu_isa_pkg::IC_POP_L: begin
                            sp    <= sp_inc;
                            state <= cpu_arch_pkg::ST_READ_LO;
                        end
                        cpu_isa_pkg::IC_POP_H: begin
                            sp    <= sp_inc;
                            state <= cpu_arch_pkg::ST_READ_HI;
                        end
                        cpu_isa_pkg::IC_IMM32: begin
                            ip    <= ip_inc + 1'b1; // Points at the low word
                            state <= cpu_arch_pkg::ST_READ_HI;
                        end
                        cpu_isa_pkg::IC_STORE_L, cpu_isa_pkg::IC_STORE_H:
                            state <= cpu_arch_pkg::ST_WRITE;
                        cpu_isa_pkg::IC_PUSH_L, cpu_isa_pkg::IC_PUSH_H: begin
                            sp    <= sp_dec;
                            state <= cpu_arch_pkg::ST_WRITE;
                        end
                        cpu_isa_pkg::IC_CALL: begin
                            sp    <= sp_dec;
                            ip    <= target;
                            state <= cpu_arch_pkg::ST_WRITE;
                        end
                        cpu_isa_pkg::IC_RET: begin
                            sp    <= sp_inc;
                            state <= cpu_arch_pkg::ST_RET_JUMP;
                        end
                        cpu_isa_pkg::IC_OUT:  out_data <= alu_result;
                        cpu_isa_pkg::IC_JUMP: ip <= taken ? target : ip_inc;
                        cpu_isa_pkg::IC_HALT: state <= cpu_arch_pkg::ST_HALT;
                        default: ; // ALU write-back, NOP and illegal words
                    endcase
                end
                cpu_arch_pkg::ST_READ_HI: begin
                    if (ld_imm32) begin
                        ip    <= ip_inc;
                        state <= cpu_arch_pkg::ST_READ_LO;
                    end else
                        state <= cpu_arch_pkg::ST_FETCH;
                end
                cpu_arch_pkg::ST_RET_JUMP: begin
                    ip    <= ram_q[AW-1:0];
                    state <= cpu_arch_pkg::ST_FETCH;
                end
                cpu_arch_pkg::ST_HALT: state <= cpu_arch_pkg::ST_HALT;
                default: state <= cpu_arch_pkg::ST_FETCH; // READ_LO and WRITE
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (state == cpu_arch_pkg::ST_EXEC) begin
            ld_wa    <= wa_dec;
            ld_imm32 <= (ins_class == cpu_isa_pkg::IC_IMM32);
            if (ins_class == cpu_isa_pkg::IC_STORE_L || ins_class == cpu_isa_pkg::IC_STORE_H)
                wr_addr <= rd1[AW-1:0];
            else
                wr_addr <= {cpu_arch_pkg::STACK_BASE, sp};
            case (ins_class)
                cpu_isa_pkg::IC_STORE_H, cpu_isa_pkg::IC_PUSH_H: wr_data <= rd0[DW-1:WW];
                cpu_isa_pkg::IC_CALL: wr_data <= {{(WW-AW){1'b0}}, ip_inc}; // Return address
                default: wr_data <= rd0[WW-1:0];
            endcase
        end
    end

endmodule

// File: verilog/cpu_core.sv
`timescale 1ns/1ns

module cpu_core (
    input  logic                             CLK,
    input  logic                             rst,
    input  logic [cpu_arch_pkg::WORD_W-1:0] ram_q,
    output logic [cpu_arch_pkg::ADDR_W-1:0] ram_addr,
    output logic [cpu_arch_pkg::WORD_W-1:0] ram_wdata,
    output logic                             ram_wren,
    input  logic                             flash_valid,
    input  logic [cpu_arch_pkg::WORD_W-1:0] flash_data,
    output logic [cpu_arch_pkg::DATA_W-1:0] out_data,
    output logic                             halted
);

    localparam int DW = cpu_arch_pkg::DATA_W;

    cpu_isa_pkg::ins_class_e          ins_class;
    cpu_isa_pkg::alu_op_e             alu_op;
    cpu_isa_pkg::branch_e             branch;
    logic                             use_imm;
    logic [1:0]                       byte_sel;
    logic [7:0]                       imm;
    logic [cpu_arch_pkg::ADDR_W-1:0] target;
    logic [cpu_arch_pkg::REG_AW-1:0] ra0;
    logic [cpu_arch_pkg::REG_AW-1:0] ra1;
    logic [cpu_arch_pkg::REG_AW-1:0] wa_dec;
    logic [cpu_arch_pkg::REG_AW-1:0] reg_wa;
    logic [DW-1:0]                    reg_wdata;
    logic                             reg_we_h;
    logic                             reg_we_l;
    logic [DW-1:0]                    rd0;
    logic [DW-1:0]                    rd1;
    logic [DW-1:0]                    alu_arg1;
    logic [DW-1:0]                    alu_result;

    assign alu_arg1 = use_imm ? {{(DW-8){1'b0}}, imm} : rd1; // ADDB and SUBB

    core_control u_core_control (
        .CLK(CLK), .rst(rst),
        .flash_valid(flash_valid), .flash_data(flash_data),
        .ram_q(ram_q), .ram_addr(ram_addr), .ram_wdata(ram_wdata), .ram_wren(ram_wren),
        .ins_class(ins_class), .branch(branch), .target(target),
        .rd0(rd0), .rd1(rd1), .alu_result(alu_result), .wa_dec(wa_dec),
        .reg_wa(reg_wa), .reg_wdata(reg_wdata), .reg_we_h(reg_we_h), .reg_we_l(reg_we_l),
        .out_data(out_data), .halted(halted)
    );

    instr_decode u_instr_decode (
        .instr(ram_q), .ins_class(ins_class), .alu_op(alu_op), .use_imm(use_imm),
        .byte_sel(byte_sel), .branch(branch), .ra0(ra0), .ra1(ra1), .wa(wa_dec),
        .imm(imm), .target(target)
    );

    alu u_alu (
        .op(alu_op), .arg0(rd0), .arg1(alu_arg1),
        .byte_sel(byte_sel), .imm(imm), .result(alu_result)
    );

    regfile u_regfile (
        .CLK(CLK), .ra0(ra0), .ra1(ra1), .wa(reg_wa), .wdata(reg_wdata),
        .we_h(reg_we_h), .we_l(reg_we_l), .rd0(rd0), .rd1(rd1)
    );

endmodule

// File: verif/tb_clock.sv
`timescale 1ns/1ns

module tb_clock #(
    parameter int PERIOD = 4
) (
    output logic CLK
);

    initial CLK = 1'b0;

    always #(PERIOD / 2) CLK = ~CLK;

endmodule

// File: verif/tb_ram.sv
`timescale 1ns/1ns

module tb_ram (
    input  logic        CLK,
    input  logic [11:0] addr,
    input  logic [15:0] wdata,
    input  logic        wren,
    output logic [15:0] q
);

    logic [15:0] mem [4096]; // Read by the testbench directly

    initial begin
        for (int i = 0; i < 4096; i++)
            mem[i] = {4'hd, 12'(i)}; // Distinct fill per address
    end

    always @(posedge CLK) begin
        if (wren)
            mem[addr] <= wdata;
        q <= mem[addr]; // Old word on a write
    end

endmodule

// File: verif/tb_core.sv
`timescale 1ns/1ns

module tb_core;

    localparam int CLK_PERIOD  = 4;
    localparam int N_TESTS     = 5;
    localparam int TEST_CYCLES = 2000;
    localparam int HALT_LIMIT  = 1000;

    logic        CLK;
    logic        rst;
    logic        flash_valid;
    logic [15:0] flash_data;
    logic [15:0] ram_q;
    logic [15:0] ram_wdata;
    logic [11:0] ram_addr;
    logic        ram_wren;
    logic [31:0] out_data;
    logic        halted;

    logic [15:0] prog [128];
    int          pc;
    int          errors;
    integer      seed;
    logic [31:0] outs [$];
    logic [31:0] last_out;
    logic        capture_en;

    tb_clock #(.PERIOD(CLK_PERIOD)) u_clock (.CLK(CLK));

    tb_ram u_ram (
        .CLK(CLK), .addr(ram_addr), .wdata(ram_wdata), .wren(ram_wren), .q(ram_q)
    );

    cpu_core u_cpu_core (
        .CLK(CLK), .rst(rst), .ram_q(ram_q), .ram_addr(ram_addr), .ram_wdata(ram_wdata),
        .ram_wren(ram_wren), .flash_valid(flash_valid), .flash_data(flash_data),
        .out_data(out_data), .halted(halted)
    );

    always @(negedge CLK) begin
        if (capture_en && out_data !== last_out) begin // Log each new OUT value
            outs.push_back(out_data);
            last_out = out_data;
        end
    end

    initial begin
        #(N_TESTS * TEST_CYCLES * CLK_PERIOD);
        $display("Watchdog expired, simulation did not finish in time");
        $display("Test FAILED");
        $finish;
    end

    function automatic logic [31:0] rnd();
        return $random(seed);
    endfunction

    function automatic logic [15:0] op_rr(input cpu_isa_pkg::major_e mj, input int rd,
                                          input int rs0, input int rs1, input int fn);
        return {1'b0, mj, 3'(rd), 3'(rs0), 3'(rs1), 2'(fn)};
    endfunction

    function automatic logic [15:0] op_misc(input cpu_isa_pkg::minor_e mn, input int rd,
                                            input int rs0);
        return {1'b0, cpu_isa_pkg::MJ_MISC, 3'(rd), 3'(rs0), mn};
    endfunction

    function automatic logic [15:0] op_imm(input cpu_isa_pkg::major_e mj, input int rd,
                                           input logic [7:0] imm);
        return {1'b0, mj, 3'(rd), imm};
    endfunction

    function automatic logic [15:0] op_br(input cpu_isa_pkg::branch_e br, input int tgt);
        return {1'b1, br, 12'(tgt)};
    endfunction

    function automatic bit branch_taken(input cpu_isa_pkg::branch_e br, input int signed v);
        case (br)
            cpu_isa_pkg::BR_JEZ:  return v == 0;
            cpu_isa_pkg::BR_JNZ:  return v != 0;
            cpu_isa_pkg::BR_JAZ:  return v > 0;
            cpu_isa_pkg::BR_JBZ:  return v < 0;
            cpu_isa_pkg::BR_JAEZ: return v >= 0;
            cpu_isa_pkg::BR_JBEZ: return v <= 0;
            default:              return 1'b1;
        endcase
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_outs(input logic [31:0] exp [$]);
        check("out_data change count", outs.size(), exp.size());
        for (int i = 0; i < exp.size() && i < outs.size(); i++)
            check($sformatf("out_data[%0d]", i), outs[i], exp[i]);
    endtask

    task automatic new_program();
        for (int i = 0; i < 128; i++)
            prog[i] = op_misc(cpu_isa_pkg::MN_END, 0, 0);
        pc = 0;
    endtask

    task automatic emit(input logic [15:0] w);
        prog[pc] = w;
        pc++;
    endtask

    task automatic emit_movd(input int rd, input logic [31:0] v);
        emit(op_misc(cpu_isa_pkg::MN_MOVD, rd, 0));
        emit(v[31:16]); // High word first
        emit(v[15:0]);
    endtask

    task automatic emit_out(input int rs);
        emit(op_misc(cpu_isa_pkg::MN_OUT, 0, rs));
    endtask

    task automatic reset_dut();
        @(negedge CLK);
        rst         = 1'b1;
        flash_valid = 1'b0;
        capture_en  = 1'b0;
        repeat (5) @(negedge CLK);
        rst        = 1'b0;
        outs.delete();
        last_out   = '0;
        capture_en = 1'b1;
    endtask

    task automatic run_program();
        int n;
        reset_dut();
        for (int i = 0; i < 128; i++) begin
            flash_valid = 1'b1;
            flash_data  = prog[i];
            @(negedge CLK);
        end
        flash_valid = 1'b0;
        n = 0;
        while (!halted && n < HALT_LIMIT) begin
            @(negedge CLK);
            n++;
        end
        if (!halted) begin
            $display("Program did not reach END within %0d cycles", HALT_LIMIT);
            errors++;
        end
    endtask

    task automatic report(input string name, input int start);
        $display("%s: %s (%0d errors)", name, (errors == start) ? "passed" : "failed",
                 errors - start);
    endtask

    task automatic test_boot();
        int          start;
        logic [31:0] r;
        start = errors;
        reset_dut();
        check("halted", halted, 0);
        check("ram_wren", ram_wren, 0);
        new_program();
        for (int i = 1; i < 128; i++) begin // Never executed, END sits at 0
            r = rnd();
            prog[i] = r[15:0];
        end
        run_program();
        for (int i = 0; i < 128; i++)
            check($sformatf("ram[%0d]", i), u_ram.mem[i], prog[i]);
        check("halted", halted, 1);
        report("boot", start);
    endtask

    task automatic test_imm();
        cpu_isa_pkg::major_e ins [4] = '{cpu_isa_pkg::MJ_MOVLL, cpu_isa_pkg::MJ_MOVLH,
                                         cpu_isa_pkg::MJ_MOVHL, cpu_isa_pkg::MJ_MOVHH};
        int          start;
        logic [31:0] cur;
        logic [31:0] r;
        logic [7:0]  b;
        logic [31:0] exp [$];
        start = errors;
        cur = rnd();
        new_program();
        emit_movd(1, cur);
        emit_out(1);
        exp.push_back(cur);
        for (int k = 0; k < 4; k++) begin
            r = rnd();
            b = cur[k*8 +: 8] ^ (r[7:0] | 8'h01); // Always a new byte
            cur[k*8 +: 8] = b;
            emit(op_imm(ins[k], 1, b));
            emit_out(1);
            exp.push_back(cur);
        end
        run_program();
        check_outs(exp);
        report("immediates", start);
    endtask

    task automatic test_alu();
        int          start;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] r;
        logic [7:0]  i1;
        logic [7:0]  i2;
        logic [31:0] exp [$];
        start = errors;
        a  = rnd();
        b  = rnd();
        r  = rnd();
        i1 = r[7:0] | 8'h01;
        i2 = r[15:8] | 8'h01;
        new_program();
        emit_movd(1, a);
        emit_movd(2, b);
        emit(op_rr(cpu_isa_pkg::MJ_ALU_RR, 3, 1, 2, 0));
        emit_out(3);
        exp.push_back(a + b);
        emit(op_rr(cpu_isa_pkg::MJ_ALU_RR, 3, 1, 2, 1));
        emit_out(3);
        exp.push_back(a - b);
        emit(op_rr(cpu_isa_pkg::MJ_LOGIC_RR, 3, 1, 2, 0));
        emit_out(3);
        exp.push_back(a & b);
        emit(op_rr(cpu_isa_pkg::MJ_LOGIC_RR, 3, 1, 2, 1));
        emit_out(3);
        exp.push_back(a | b);
        emit(op_rr(cpu_isa_pkg::MJ_LOGIC_RR, 3, 1, 2, 2));
        emit_out(3);
        exp.push_back(a ^ b);
        emit(op_misc(cpu_isa_pkg::MN_NOT, 3, 1));
        emit_out(3);
        exp.push_back(~a);
        emit(op_misc(cpu_isa_pkg::MN_NEG, 3, 1));
        emit_out(3);
        exp.push_back(-a);
        emit(op_misc(cpu_isa_pkg::MN_MOV, 3, 2));
        emit_out(3);
        exp.push_back(b);
        emit(op_imm(cpu_isa_pkg::MJ_ADDB, 2, i1));
        emit_out(2);
        exp.push_back(b + i1);
        emit(op_imm(cpu_isa_pkg::MJ_SUBB, 1, i2));
        emit_out(1);
        exp.push_back(a - i2);
        run_program();
        check_outs(exp);
        report("alu", start);
    endtask

    task automatic test_branch();
        cpu_isa_pkg::branch_e kinds [7] = '{cpu_isa_pkg::BR_JMP, cpu_isa_pkg::BR_JEZ,
                                            cpu_isa_pkg::BR_JNZ, cpu_isa_pkg::BR_JAZ,
                                            cpu_isa_pkg::BR_JBZ, cpu_isa_pkg::BR_JAEZ,
                                            cpu_isa_pkg::BR_JBEZ};
        int          start;
        logic [31:0] vals [3];
        logic [31:0] mask;
        start = errors;
        vals[0] = '0;
        vals[1] = (rnd() & 32'h7fff_ffff) | 32'h1;
        vals[2] = rnd() | 32'h8000_0000;
        for (int n = 0; n < 3; n++) begin
            new_program();
            mask = '0;
            emit_movd(5, vals[n]);
            emit_movd(4, 0);
            for (int k = 0; k < 7; k++) begin
                emit(op_br(kinds[k], pc + 2)); // Skips the marker when taken
                emit(op_imm(cpu_isa_pkg::MJ_ADDB, 4, 8'(1 << k)));
                if (!branch_taken(kinds[k], vals[n]))
                    mask |= 32'(1 << k);
            end
            emit_out(4);
            run_program();
            check($sformatf("out_data for r5 %h", vals[n]), out_data, mask);
        end
        report("branches", start);
    endtask

    task automatic test_mem();
        int          start;
        int          call_at;
        logic [31:0] v;
        logic [31:0] w;
        logic [31:0] r;
        logic [31:0] addr;
        logic [31:0] exp [$];
        start = errors;
        v    = rnd();
        w    = rnd();
        r    = rnd();
        addr = 32'h400 + {23'd0, r[8:0]}; // Clear of program and stack
        new_program();
        emit_movd(1, v);
        emit_movd(2, addr);
        emit_movd(3, addr + 1);
        emit(op_rr(cpu_isa_pkg::MJ_STORE, 0, 1, 2, 0));
        emit(op_rr(cpu_isa_pkg::MJ_STORE, 0, 1, 3, 1));
        emit(op_misc(cpu_isa_pkg::MN_LDRAML, 4, 2));
        emit(op_misc(cpu_isa_pkg::MN_LDRAMH, 4, 3));
        emit_out(4);
        emit_movd(6, w);
        emit(op_misc(cpu_isa_pkg::MN_PUSHH, 0, 6));
        emit(op_misc(cpu_isa_pkg::MN_PUSHL, 0, 6));
        emit(op_misc(cpu_isa_pkg::MN_POPL, 7, 0));
        emit(op_misc(cpu_isa_pkg::MN_POPH, 7, 0));
        emit_out(7);
        call_at = pc;
        emit(op_br(cpu_isa_pkg::BR_CALL, 100));
        emit_out(1);
        pc = 100; // Subroutine
        emit_out(2);
        emit(op_misc(cpu_isa_pkg::MN_RET, 0, 0));
        exp = '{v, w, addr, v};
        run_program();
        check_outs(exp);
        check("ram[addr]", u_ram.mem[addr[11:0]], v[15:0]);
        check("ram[addr+1]", u_ram.mem[addr[11:0] + 12'd1], v[31:16]);
        check("ram[stack top]", u_ram.mem[{2'b11, 10'h3ff}], call_at + 1);
        check("ram[stack top-1]", u_ram.mem[{2'b11, 10'h3fe}], w[15:0]);
        report("memory and stack", start);
    endtask

    initial begin
        seed        = 32'h3da49424;
        errors      = 0;
        rst         = 1'b1;
        flash_valid = 1'b0;
        flash_data  = '0;
        capture_en  = 1'b0;
        last_out    = '0;
        test_boot();
        test_imm();
        test_alu();
        test_branch();
        test_mem();
        $display("Tests run: %0d, errors: %0d", N_TESTS, errors);
        if (errors == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

endmodule

// File: all.f
verilog/cpu_arch_pkg.sv
verilog/cpu_isa_pkg.sv
verilog/regfile.sv
verilog/alu.sv
verilog/instr_decode.sv
verilog/core_control.sv
verilog/cpu_core.sv
verif/tb_clock.sv
verif/tb_ram.sv
verif/tb_core.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_core -f all.f -o tb_core_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_core_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^Test OK$" sim.log; then
    exit 0
fi
exit 1
